// File: verilog/uart_regmap_pkg.sv
package uart_regmap_pkg;

    // Only the low byte of the AXI address selects a register
    localparam int REG_ADDR_W = 8;

    // Bus word width of the AXI4-Lite port
    localparam int AXIL_DATA_W = 32;

    // ========================================================================
    // Register offsets
    // ========================================================================
    localparam logic [REG_ADDR_W-1:0] ADDR_CR1 = 8'h00;
    localparam logic [REG_ADDR_W-1:0] ADDR_BRR = 8'h08;
    localparam logic [REG_ADDR_W-1:0] ADDR_ISR = 8'h0C;
    localparam logic [REG_ADDR_W-1:0] ADDR_ICR = 8'h10;
    localparam logic [REG_ADDR_W-1:0] ADDR_RDR = 8'h14;
    localparam logic [REG_ADDR_W-1:0] ADDR_TDR = 8'h18;

    // Response code for every transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: verilog/uart_fields_pkg.sv
package uart_fields_pkg;

    // ========================================================================
    // ISR bit positions, shared by the ICR clear bits
    // ========================================================================
    localparam int ISR_PE   = 0;
    localparam int ISR_FE   = 1;
    localparam int ISR_ORE  = 2;
    localparam int ISR_IDLE = 3;
    localparam int ISR_RXNE = 4;
    localparam int ISR_TC   = 5;
    localparam int ISR_TXE  = 6;
    localparam int ISR_BUSY = 7;
    localparam int ISR_W    = 8;

    // Event flags that stay set until cleared through ICR
    localparam logic [ISR_W-1:0] STICKY_MASK = ISR_W'((1 << ISR_PE) | (1 << ISR_FE) |
        (1 << ISR_ORE) | (1 << ISR_IDLE) | (1 << ISR_TC));

    // CR1 fields
    localparam int CR1_UE       = 0;
    localparam int CR1_TE       = 1;
    localparam int CR1_RE       = 2;
    localparam int CR1_PCE      = 3;
    localparam int CR1_PS       = 4;
    localparam int CR1_M        = 5;
    localparam int CR1_DATA_LSB = 6;
    localparam int CR1_DATA_MSB = 7;

    localparam logic [31:0] CR1_MASK = 32'((1 << CR1_UE) | (1 << CR1_TE) | (1 << CR1_RE) |
        (1 << CR1_PCE) | (1 << CR1_PS) | (1 << CR1_M) | (1 << CR1_DATA_LSB) |
        (1 << CR1_DATA_MSB));

    // Baud divisor width
    localparam int BRR_W = 16;

endpackage

// File: verilog/axil_wr_slave.sv
`timescale 1ns/1ns

module axil_wr_slave import uart_regmap_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ADDR_W-1:0]      i_awaddr,
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  logic [AXIL_DATA_W-1:0] i_wdata,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output logic [1:0]             o_bresp,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    output logic                   o_wr_en,
    output logic [REG_ADDR_W-1:0]  o_wr_addr,
    output logic [AXIL_DATA_W-1:0] o_wr_data
);

    logic accept;
    logic bvalid_q;

    // Address and data are taken together, once the response slot is free
    assign accept    = i_awvalid && i_wvalid && (!bvalid_q || i_bready);
    assign o_awready = accept;
    assign o_wready  = accept;
    assign o_bvalid  = bvalid_q;
    assign o_bresp   = RESP_OKAY;

    assign o_wr_en   = accept;
    assign o_wr_addr = i_awaddr[REG_ADDR_W-1:0];
    assign o_wr_data = i_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (accept) begin
            bvalid_q <= 1'b1;
        end else if (i_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        o_bvalid && !i_bready |=> o_bvalid);

endmodule

// File: verilog/axil_rd_slave.sv
`timescale 1ns/1ns

module axil_rd_slave import uart_regmap_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ADDR_W-1:0]      i_araddr,
    input  logic                   i_arvalid,
    output logic                   o_arready,
    output logic [AXIL_DATA_W-1:0] o_rdata,
    output logic [1:0]             o_rresp,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output logic                   o_rd_en,
    output logic [REG_ADDR_W-1:0]  o_rd_addr,
    input  logic [AXIL_DATA_W-1:0] i_rd_data
);

    logic                   accept;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;

    assign accept    = i_arvalid && (!rvalid_q || i_rready);
    assign o_arready = accept;
    assign o_rd_en   = accept;
    assign o_rd_addr = i_araddr[REG_ADDR_W-1:0];
    assign o_rvalid  = rvalid_q;
    assign o_rdata   = rdata_q;
    assign o_rresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (accept) begin
            rvalid_q <= 1'b1;
        end else if (i_rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Read data is sampled from the register file at the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= i_rd_data;
        end
    end

    a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

// File: verilog/uart_reg_file.sv
`timescale 1ns/1ns

module uart_reg_file import uart_regmap_pkg::*, uart_fields_pkg::*; #(
    parameter int CHAR_W = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_wr_en,
    input  logic [REG_ADDR_W-1:0]  i_wr_addr,
    input  logic [AXIL_DATA_W-1:0] i_wr_data,
    input  logic                   i_rd_en,
    input  logic [REG_ADDR_W-1:0]  i_rd_addr,
    output logic [AXIL_DATA_W-1:0] o_rd_data,
    output logic [31:0]            o_cr1,
    output logic [BRR_W-1:0]       o_brr,
    output logic                   o_tdr_wr,
    output logic [CHAR_W-1:0]      o_tdr_data,
    output logic                   o_rdr_rd,
    input  logic [CHAR_W-1:0]      i_rdr_data,
    input  logic [ISR_W-1:0]       i_isr,
    output logic [ISR_W-1:0]       o_icr_clr
);

    logic [31:0]       cr1_q;
    logic [BRR_W-1:0]  brr_q;
    logic [CHAR_W-1:0] tdr_q;
    logic              icr_wr;

    // ========================================================================
    // Write decode
    // ========================================================================
    assign o_tdr_wr   = i_wr_en && (i_wr_addr == ADDR_TDR);
    assign o_tdr_data = i_wr_data[CHAR_W-1:0];
    assign icr_wr     = i_wr_en && (i_wr_addr == ADDR_ICR);
    // Clear bits outside the sticky flags have no effect
    assign o_icr_clr  = icr_wr ? (i_wr_data[ISR_W-1:0] & STICKY_MASK) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cr1_q <= '0;
            brr_q <= '0;
            tdr_q <= '0;
        end else if (i_wr_en) begin
            case (i_wr_addr)
                ADDR_CR1: cr1_q <= i_wr_data[31:0] & CR1_MASK;
                ADDR_BRR: brr_q <= i_wr_data[BRR_W-1:0];
                // Last character written by the CPU, for readback
                ADDR_TDR: tdr_q <= i_wr_data[CHAR_W-1:0];
                default: ;
            endcase
        end
    end

    assign o_cr1 = cr1_q;
    assign o_brr = brr_q;

    // ========================================================================
    // Read decode
    // ========================================================================
    assign o_rdr_rd = i_rd_en && (i_rd_addr == ADDR_RDR);

    always_comb begin
        case (i_rd_addr)
            ADDR_CR1: o_rd_data = AXIL_DATA_W'(cr1_q);
            ADDR_BRR: o_rd_data = AXIL_DATA_W'(brr_q);
            ADDR_ISR: o_rd_data = AXIL_DATA_W'(i_isr);
            ADDR_RDR: o_rd_data = AXIL_DATA_W'(i_rdr_data);
            ADDR_TDR: o_rd_data = AXIL_DATA_W'(tdr_q);
            // ICR is write only
            default:  o_rd_data = '0;
        endcase
    end

endmodule

// File: verilog/uart_tx_buffer.sv
`timescale 1ns/1ns

module uart_tx_buffer #(
    parameter int CHAR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_tdr_wr,
    input  logic [CHAR_W-1:0] i_tdr_data,
    output logic [CHAR_W-1:0] o_tx_tdata,
    output logic              o_tx_tvalid,
    input  logic              i_tx_tready,
    output logic              o_empty
);

    logic              valid_q;
    logic [CHAR_W-1:0] data_q;

    // Loads only into an empty slot, a write while full is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (i_tdr_wr && !valid_q) begin
            valid_q <= 1'b1;
        end else if (valid_q && i_tx_tready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tdr_wr && !valid_q) begin
            data_q <= i_tdr_data;
        end
    end

    assign o_tx_tdata  = data_q;
    assign o_tx_tvalid = valid_q;
    assign o_empty     = !valid_q;

    a_tdata_stable: assert property (@(posedge clk) disable iff (rst)
        o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata));

endmodule

// File: verilog/uart_rx_buffer.sv
`timescale 1ns/1ns

module uart_rx_buffer #(
    parameter int CHAR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [CHAR_W-1:0] i_rx_tdata,
    input  logic              i_rx_tvalid,
    output logic              o_rx_tready,
    input  logic              i_rdr_rd,
    output logic [CHAR_W-1:0] o_rdr_data,
    output logic              o_full
);

    logic              full_q;
    logic [CHAR_W-1:0] data_q;
    logic              capture;

    // One entry, so the receiver is held off until the CPU reads RDR
    assign o_rx_tready = !full_q;
    assign capture     = i_rx_tvalid && !full_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
            data_q <= '0;
        end else if (capture) begin
            full_q <= 1'b1;
            data_q <= i_rx_tdata;
        end else if (i_rdr_rd) begin
            full_q <= 1'b0;
        end
    end

    assign o_rdr_data = data_q;
    assign o_full     = full_q;

endmodule

// File: verilog/uart_status_reg.sv
`timescale 1ns/1ns

module uart_status_reg import uart_fields_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_pe,
    input  logic             i_fe,
    input  logic             i_ore,
    input  logic             i_idle,
    input  logic             i_tc,
    input  logic             i_busy,
    input  logic             i_rx_full,
    input  logic             i_tx_empty,
    input  logic [ISR_W-1:0] i_icr_clr,
    output logic [ISR_W-1:0] o_isr
);

    localparam logic [ISR_W-1:0] LIVE_MASK =
        ISR_W'((1 << ISR_RXNE) | (1 << ISR_TXE) | (1 << ISR_BUSY));

    logic [ISR_W-1:0] set_vec;
    logic [ISR_W-1:0] isr_q;

    always_comb begin
        set_vec           = '0;
        set_vec[ISR_PE]   = i_pe;
        set_vec[ISR_FE]   = i_fe;
        set_vec[ISR_ORE]  = i_ore;
        set_vec[ISR_IDLE] = i_idle;
        set_vec[ISR_TC]   = i_tc;
        set_vec[ISR_RXNE] = i_rx_full;
        set_vec[ISR_TXE]  = i_tx_empty;
        set_vec[ISR_BUSY] = i_busy;
    end

    // Set beats clear on the sticky flags
    // Live bits just follow their source
    always_ff @(posedge clk) begin
        if (rst) begin
            isr_q <= '0;
        end else begin
            isr_q <= (((isr_q & ~i_icr_clr) | set_vec) & STICKY_MASK) | (set_vec & LIVE_MASK);
        end
    end

    assign o_isr = isr_q;

endmodule

// File: verilog/uart_regs_top.sv
`timescale 1ns/1ns

module uart_regs_top import uart_regmap_pkg::*, uart_fields_pkg::*; #(
    parameter int ADDR_W = 32,
    parameter int CHAR_W = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    // AXI4-Lite write channel
    input  logic [ADDR_W-1:0]      i_awaddr,
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  logic [AXIL_DATA_W-1:0] i_wdata,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output logic [1:0]             o_bresp,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    // AXI4-Lite read channel
    input  logic [ADDR_W-1:0]      i_araddr,
    input  logic                   i_arvalid,
    output logic                   o_arready,
    output logic [AXIL_DATA_W-1:0] o_rdata,
    output logic [1:0]             o_rresp,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    // UART core side
    output logic [31:0]            o_cr1,
    output logic [BRR_W-1:0]       o_brr,
    output logic [CHAR_W-1:0]      o_tx_tdata,
    output logic                   o_tx_tvalid,
    input  logic                   i_tx_tready,
    input  logic [CHAR_W-1:0]      i_rx_tdata,
    input  logic                   i_rx_tvalid,
    output logic                   o_rx_tready,
    input  logic                   i_pe,
    input  logic                   i_fe,
    input  logic                   i_ore,
    input  logic                   i_idle,
    input  logic                   i_tc,
    input  logic                   i_busy
);

    logic                   wr_en;
    logic [REG_ADDR_W-1:0]  wr_addr;
    logic [AXIL_DATA_W-1:0] wr_data;
    logic                   rd_en;
    logic [REG_ADDR_W-1:0]  rd_addr;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic                   tdr_wr;
    logic [CHAR_W-1:0]      tdr_data;
    logic                   tx_empty;
    logic                   rdr_rd;
    logic [CHAR_W-1:0]      rdr_data;
    logic                   rx_full;
    logic [ISR_W-1:0]       isr;
    logic [ISR_W-1:0]       icr_clr;

    // ========================================================================
    // Bus channels
    // ========================================================================
    axil_wr_slave #(.ADDR_W(ADDR_W)) u_wr (
        .clk(clk), .rst(rst),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
    );

    axil_rd_slave #(.ADDR_W(ADDR_W)) u_rd (
        .clk(clk), .rst(rst),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_data(rd_data)
    );

    // ========================================================================
    // Registers and data path
    // ========================================================================
    uart_reg_file #(.CHAR_W(CHAR_W)) u_regs (
        .clk(clk), .rst(rst),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
        .o_cr1(o_cr1), .o_brr(o_brr),
        .o_tdr_wr(tdr_wr), .o_tdr_data(tdr_data),
        .o_rdr_rd(rdr_rd), .i_rdr_data(rdr_data),
        .i_isr(isr), .o_icr_clr(icr_clr)
    );

    uart_tx_buffer #(.CHAR_W(CHAR_W)) u_tx (
        .clk(clk), .rst(rst),
        .i_tdr_wr(tdr_wr), .i_tdr_data(tdr_data),
        .o_tx_tdata(o_tx_tdata), .o_tx_tvalid(o_tx_tvalid), .i_tx_tready(i_tx_tready),
        .o_empty(tx_empty)
    );

    uart_rx_buffer #(.CHAR_W(CHAR_W)) u_rx (
        .clk(clk), .rst(rst),
        .i_rx_tdata(i_rx_tdata), .i_rx_tvalid(i_rx_tvalid), .o_rx_tready(o_rx_tready),
        .i_rdr_rd(rdr_rd), .o_rdr_data(rdr_data), .o_full(rx_full)
    );

    uart_status_reg u_status (
        .clk(clk), .rst(rst),
        .i_pe(i_pe), .i_fe(i_fe), .i_ore(i_ore), .i_idle(i_idle),
        .i_tc(i_tc), .i_busy(i_busy),
        .i_rx_full(rx_full), .i_tx_empty(tx_empty),
        .i_icr_clr(icr_clr), .o_isr(isr)
    );

endmodule

// File: verification/uart_regs_tb.sv
`timescale 1ns/1ns

module uart_regs_tb
    import uart_regmap_pkg::*, uart_fields_pkg::*;
();

    localparam int ADDR_W     = 32;
    localparam int CHAR_W     = 8;
    // Roughly 60 bus transfers of at most a few dozen cycles each plus margin
    localparam int MAX_CYCLES = 3000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [ADDR_W-1:0]      i_awaddr;
    logic                   i_awvalid;
    logic                   o_awready;
    logic [AXIL_DATA_W-1:0] i_wdata;
    logic                   i_wvalid;
    logic                   o_wready;
    logic [1:0]             o_bresp;
    logic                   o_bvalid;
    logic                   i_bready;
    logic [ADDR_W-1:0]      i_araddr;
    logic                   i_arvalid;
    logic                   o_arready;
    logic [AXIL_DATA_W-1:0] o_rdata;
    logic [1:0]             o_rresp;
    logic                   o_rvalid;
    logic                   i_rready;
    logic [31:0]            o_cr1;
    logic [BRR_W-1:0]       o_brr;
    logic [CHAR_W-1:0]      o_tx_tdata;
    logic                   o_tx_tvalid;
    logic                   i_tx_tready;
    logic [CHAR_W-1:0]      i_rx_tdata;
    logic                   i_rx_tvalid;
    logic                   o_rx_tready;
    logic                   i_pe;
    logic                   i_fe;
    logic                   i_ore;
    logic                   i_idle;
    logic                   i_tc;
    logic                   i_busy;

    // Reference model of the register state
    logic [31:0]       exp_cr1;
    logic [BRR_W-1:0]  exp_brr;
    logic [CHAR_W-1:0] exp_tdr;
    logic [CHAR_W-1:0] exp_tx;
    logic              exp_tx_full;
    logic [CHAR_W-1:0] exp_rx;
    logic              exp_rx_full;
    logic [ISR_W-1:0]  exp_isr;
    logic [31:0]       exp_rdata;
    logic              exp_wr_take;
    logic              exp_rd_take;
    logic [31:0]       lcg_state;

    int wr_acc;
    int wr_rsp;
    int rd_acc;
    int rd_rsp;
    int n_writes    = 0;
    int n_reads     = 0;
    int error_count = 0;
    int cycles      = 0;

    uart_regs_top #(.ADDR_W(ADDR_W), .CHAR_W(CHAR_W)) dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] read_value(input logic [REG_ADDR_W-1:0] addr);
        case (addr)
            ADDR_CR1: return exp_cr1;
            ADDR_BRR: return 32'(exp_brr);
            ADDR_ISR: return 32'(exp_isr);
            ADDR_RDR: return 32'(exp_rx);
            ADDR_TDR: return 32'(exp_tdr);
            default:  return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_fault(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    // ========================================================================
    // Cycle model updated on the same edges as the DUT
    // ========================================================================
    always @(posedge clk) begin : model_update
        logic             wr_hit;
        logic             rd_hit;
        logic [ISR_W-1:0] events;
        logic [ISR_W-1:0] clr;
        wr_hit = i_awvalid && i_wvalid && o_awready;
        rd_hit = i_arvalid && o_arready;
        events = '0;
        events[ISR_PE]   = i_pe;
        events[ISR_FE]   = i_fe;
        events[ISR_ORE]  = i_ore;
        events[ISR_IDLE] = i_idle;
        events[ISR_TC]   = i_tc;
        clr = (wr_hit && i_awaddr[REG_ADDR_W-1:0] == ADDR_ICR) ? i_wdata[ISR_W-1:0] : '0;
        if (rst) begin
            {exp_cr1, exp_brr, exp_tdr, exp_tx, exp_rx, exp_isr, exp_rdata} <= '0;
            {exp_tx_full, exp_rx_full} <= 2'b00;
            {wr_acc, wr_rsp, rd_acc, rd_rsp} <= '0;
        end else begin
            if (wr_hit) begin
                wr_acc <= wr_acc + 1;
                case (i_awaddr[REG_ADDR_W-1:0])
                    ADDR_CR1: exp_cr1 <= i_wdata & CR1_MASK;
                    ADDR_BRR: exp_brr <= i_wdata[BRR_W-1:0];
                    ADDR_TDR: exp_tdr <= i_wdata[CHAR_W-1:0];
                    default: ;
                endcase
            end
            if (rd_hit) begin
                rd_acc    <= rd_acc + 1;
                exp_rdata <= read_value(i_araddr[REG_ADDR_W-1:0]);
            end
            wr_rsp <= wr_rsp + int'(o_bvalid && i_bready);
            rd_rsp <= rd_rsp + int'(o_rvalid && i_rready);
            // One-entry TX slot that drops writes while full
            if (wr_hit && i_awaddr[REG_ADDR_W-1:0] == ADDR_TDR && !exp_tx_full) begin
                exp_tx_full <= 1'b1;
                exp_tx      <= i_wdata[CHAR_W-1:0];
            end else if (exp_tx_full && i_tx_tready) begin
                exp_tx_full <= 1'b0;
            end
            if (i_rx_tvalid && !exp_rx_full) begin
                exp_rx_full <= 1'b1;
                exp_rx      <= i_rx_tdata;
            end else if (rd_hit && i_araddr[REG_ADDR_W-1:0] == ADDR_RDR) begin
                exp_rx_full <= 1'b0;
            end
            exp_isr           <= ((exp_isr & ~clr) | events) & STICKY_MASK;
            exp_isr[ISR_RXNE] <= exp_rx_full;
            exp_isr[ISR_TXE]  <= !exp_tx_full;
            exp_isr[ISR_BUSY] <= i_busy;
        end
    end

    // A request is taken only while no earlier response is outstanding
    assign exp_wr_take = i_awvalid && i_wvalid && (wr_acc == wr_rsp || i_bready);
    assign exp_rd_take = i_arvalid && (rd_acc == rd_rsp || i_rready);

    // ========================================================================
    // Checks
    // ========================================================================
    a_cr1: assert property (@(posedge clk) disable iff (rst) o_cr1 == exp_cr1)
        else report_mismatch("o_cr1", $sampled(exp_cr1), $sampled(o_cr1));
    a_brr: assert property (@(posedge clk) disable iff (rst) o_brr == exp_brr)
        else report_mismatch("o_brr", $sampled(exp_brr), $sampled(o_brr));
    a_awready: assert property (@(posedge clk) disable iff (rst) o_awready == exp_wr_take)
        else report_mismatch("o_awready", $sampled(exp_wr_take), $sampled(o_awready));
    a_wready: assert property (@(posedge clk) disable iff (rst) o_wready == exp_wr_take)
        else report_mismatch("o_wready", $sampled(exp_wr_take), $sampled(o_wready));
    a_arready: assert property (@(posedge clk) disable iff (rst) o_arready == exp_rd_take)
        else report_mismatch("o_arready", $sampled(exp_rd_take), $sampled(o_arready));
    a_rdata: assert property (@(posedge clk) disable iff (rst)
        o_rvalid && i_rready |-> o_rdata == exp_rdata)
        else report_mismatch("o_rdata", $sampled(exp_rdata), $sampled(o_rdata));
    a_rresp: assert property (@(posedge clk) disable iff (rst) o_rvalid |-> o_rresp == RESP_OKAY)
        else report_mismatch("o_rresp", RESP_OKAY, $sampled(o_rresp));
    a_bresp: assert property (@(posedge clk) disable iff (rst) o_bvalid |-> o_bresp == RESP_OKAY)
        else report_mismatch("o_bresp", RESP_OKAY, $sampled(o_bresp));
    a_bhold: assert property (@(posedge clk) disable iff (rst) o_bvalid && !i_bready |=> o_bvalid)
        else report_fault("bvalid dropped before bready");
    a_rhold: assert property (@(posedge clk) disable iff (rst) o_rvalid && !i_rready |=> o_rvalid)
        else report_fault("rvalid dropped before rready");
    // Exactly one response per accepted request
    a_bonce: assert property (@(posedge clk) disable iff (rst) o_bvalid == (wr_acc != wr_rsp))
        else report_mismatch("o_bvalid", $sampled(wr_acc != wr_rsp), $sampled(o_bvalid));
    a_ronce: assert property (@(posedge clk) disable iff (rst) o_rvalid == (rd_acc != rd_rsp))
        else report_mismatch("o_rvalid", $sampled(rd_acc != rd_rsp), $sampled(o_rvalid));
    a_tvalid: assert property (@(posedge clk) disable iff (rst) o_tx_tvalid == exp_tx_full)
        else report_mismatch("o_tx_tvalid", $sampled(exp_tx_full), $sampled(o_tx_tvalid));
    a_tdata: assert property (@(posedge clk) disable iff (rst)
        o_tx_tvalid |-> o_tx_tdata == exp_tx)
        else report_mismatch("o_tx_tdata", $sampled(exp_tx), $sampled(o_tx_tdata));
    a_thold: assert property (@(posedge clk) disable iff (rst)
        o_tx_tvalid && !i_tx_tready |=> $stable(o_tx_tdata))
        else report_fault("o_tx_tdata changed under back-pressure");
    a_rxrdy: assert property (@(posedge clk) disable iff (rst) o_rx_tready == !exp_rx_full)
        else report_mismatch("o_rx_tready", $sampled(!exp_rx_full), $sampled(o_rx_tready));

    // ========================================================================
    // Bus tasks with random bready and rready stalls
    // ========================================================================
    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        logic        done;
        logic [31:0] r;
        i_awaddr  = ADDR_W'(addr);
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = o_awready;
            @(posedge clk);
            #1;
        end
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        n_writes++;
        done = 1'b0;
        while (!done) begin
            r = rand_word();
            i_bready = r[31];
            @(negedge clk);
            done = o_bvalid && i_bready;
            @(posedge clk);
            #1;
        end
        i_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr);
        logic        done;
        logic [31:0] r;
        i_araddr  = ADDR_W'(addr);
        i_arvalid = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = o_arready;
            @(posedge clk);
            #1;
        end
        i_arvalid = 1'b0;
        n_reads++;
        done = 1'b0;
        while (!done) begin
            r = rand_word();
            i_rready = r[30];
            @(negedge clk);
            done = o_rvalid && i_rready;
            @(posedge clk);
            #1;
        end
        i_rready = 1'b0;
    endtask

    task automatic pulse_events(input logic [ISR_W-1:0] bits);
        i_pe   = bits[ISR_PE];
        i_fe   = bits[ISR_FE];
        i_ore  = bits[ISR_ORE];
        i_idle = bits[ISR_IDLE];
        i_tc   = bits[ISR_TC];
        @(posedge clk);
        #1;
        {i_pe, i_fe, i_ore, i_idle, i_tc} = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles, %0d errors", cycles,
                     error_count);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        lcg_state = 32'd41;
        rst = 1'b1;
        {i_awaddr, i_awvalid, i_wdata, i_wvalid, i_bready} = '0;
        {i_araddr, i_arvalid, i_rready} = '0;
        {i_tx_tready, i_rx_tdata, i_rx_tvalid} = '0;
        {i_pe, i_fe, i_ore, i_idle, i_tc, i_busy} = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle(2);

        // Control registers and then unmapped offsets
        repeat (4) begin
            write_reg(ADDR_CR1, rand_word());
            write_reg(ADDR_BRR, rand_word());
            read_reg(ADDR_CR1);
            read_reg(ADDR_BRR);
        end
        write_reg(8'h04, 32'hFFFF_FFFF);
        write_reg(ADDR_ISR, 32'hFFFF_FFFF);
        read_reg(8'h04);
        read_reg(8'h1C);
        read_reg(ADDR_ICR);
        read_reg(8'hF0);

        // TX slot held under back-pressure with the second write dropped
        write_reg(ADDR_TDR, rand_word());
        idle(3);
        write_reg(ADDR_TDR, rand_word());
        read_reg(ADDR_ISR);
        read_reg(ADDR_TDR);
        i_tx_tready = 1'b1;
        while (o_tx_tvalid) begin
            idle(1);
        end
        i_tx_tready = 1'b0;
        idle(2);
        read_reg(ADDR_ISR);

        // RX slot where a second character waits until RDR is read
        r = rand_word();
        i_rx_tdata  = r[CHAR_W-1:0];
        i_rx_tvalid = 1'b1;
        idle(1);
        r = rand_word();
        i_rx_tdata = r[CHAR_W-1:0];
        idle(3);
        read_reg(ADDR_ISR);
        read_reg(ADDR_RDR);
        idle(1);
        i_rx_tvalid = 1'b0;
        read_reg(ADDR_RDR);
        idle(2);
        read_reg(ADDR_ISR);

        // Sticky flags and ICR clears
        pulse_events(ISR_W'((1 << ISR_PE) | (1 << ISR_FE) | (1 << ISR_ORE)));
        pulse_events(ISR_W'((1 << ISR_IDLE) | (1 << ISR_TC)));
        read_reg(ADDR_ISR);
        write_reg(ADDR_ICR, 32'((1 << ISR_PE) | (1 << ISR_ORE)));
        read_reg(ADDR_ISR);
        // Event held high across its own clear
        i_fe = 1'b1;
        write_reg(ADDR_ICR, 32'((1 << ISR_FE) | (1 << ISR_TC)));
        i_fe   = 1'b0;
        i_busy = 1'b1;
        idle(2);
        read_reg(ADDR_ISR);
        i_busy = 1'b0;
        write_reg(ADDR_ICR, 32'hFFFF_FFFF);
        idle(2);
        read_reg(ADDR_ISR);

        // Mixed traffic under random stalls
        repeat (10) begin
            write_reg(ADDR_BRR, rand_word());
            read_reg(ADDR_BRR);
        end

        idle(4);
        $display("Done: %0d writes, %0d reads, %0d errors", n_writes, n_reads, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: uart_regs.f
verilog/uart_regmap_pkg.sv
verilog/uart_fields_pkg.sv
verilog/axil_wr_slave.sv
verilog/axil_rd_slave.sv
verilog/uart_reg_file.sv
verilog/uart_tx_buffer.sv
verilog/uart_rx_buffer.sv
verilog/uart_status_reg.sv
verilog/uart_regs_top.sv
verification/uart_regs_tb.sv

// File: Bender.yml
package:
  name: uart_regs

sources:
  - verilog/uart_regmap_pkg.sv
  - verilog/uart_fields_pkg.sv
  - verilog/axil_wr_slave.sv
  - verilog/axil_rd_slave.sv
  - verilog/uart_reg_file.sv
  - verilog/uart_tx_buffer.sv
  - verilog/uart_rx_buffer.sv
  - verilog/uart_status_reg.sv
  - verilog/uart_regs_top.sv
  - target: test
    files:
      - verification/uart_regs_tb.sv
